// File: common/rename_pkg.sv
`default_nettype none

package rename_pkg;

    ////////////////////////////////////////
    // register file and queue sizes
    ////////////////////////////////////////

    localparam int NUM_AR     = 32;               // architectural regs
    localparam int NUM_PR     = 64;               // physical regs
    localparam int FREE_DEPTH = NUM_PR - NUM_AR;  // prs unmapped at reset
    localparam int ROB_DEPTH  = 16;               // rob entries, power of two

    // index widths
    localparam int AR_W  = $clog2(NUM_AR);
    localparam int PR_W  = $clog2(NUM_PR);
    localparam int ROB_W = $clog2(ROB_DEPTH);

    ////////////////////////////////////////
    // recovery fsm state encoding
    ////////////////////////////////////////

    localparam logic ST_RUN     = 1'b0;  // normal operation
    localparam logic ST_RECOVER = 1'b1;  // one cycle of map / free list restore

    ////////////////////////////////////////
    // index types
    ////////////////////////////////////////

    typedef logic [AR_W-1:0]  ar_idx_t;   // architectural register number
    typedef logic [PR_W-1:0]  pr_idx_t;   // physical register number
    typedef logic [ROB_W-1:0] rob_idx_t;  // rob slot

    // note that FREE_DEPTH must stay a power of two as well,
    // the free list ring wraps its pointers without compare

endpackage

`default_nettype wire

// File: common/retire_if.sv
`timescale 1ns/1ps
`default_nettype none

// one retiring instruction per cycle, rob head to arch map and free list
interface retire_if;
    import rename_pkg::*;

    logic    valid;   // strobe, one per retired instr
    ar_idx_t ar;      // destination ar of the retiring instr
    pr_idx_t pr_new;  // becomes the committed mapping of ar
    pr_idx_t pr_old;  // previous mapping, returns to the free list

    // rob side
    modport source (
        output valid, ar, pr_new, pr_old
    );

    // arch map and free list side
    modport sink (
        input valid, ar, pr_new, pr_old
    );

endinterface

`default_nettype wire

// File: hdl/ring_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ring_counter #(
    parameter int DEPTH = 16  // power of two
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 push,   // advance tail
    input  wire logic                 pop,    // advance head
    input  wire logic                 clear,  // empty the ring
    input  wire logic                 fill,   // head to tail, count full
    output logic [$clog2(DEPTH)-1:0]  head,
    output logic [$clog2(DEPTH)-1:0]  tail,
    output logic                      empty,
    output logic                      full
);

    logic [$clog2(DEPTH):0] count;  // extra msb tells full from empty

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            head  <= '0;
            tail  <= '0;
            count <= fill ? ($clog2(DEPTH)+1)'(DEPTH) : '0;  // free list resets full
        end else if (fill) begin
            head  <= tail;  // every slot counts as occupied again
            count <= ($clog2(DEPTH)+1)'(DEPTH);
        end else begin
            if (push) begin
                tail <= tail + 1'b1;  // wraps at DEPTH
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push+pop
            endcase
        end
    end

    assign empty = (count == '0);
    assign full  = (count == ($clog2(DEPTH)+1)'(DEPTH));

endmodule

`default_nettype wire

// File: hdl/recovery_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module recovery_fsm (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic flush,    // mispredict strobe
    output logic      hold,     // flush cycle plus recover cycle
    output logic      restore   // recover cycle only
);
    import rename_pkg::*;

    logic state;  // ST_RUN or ST_RECOVER

    // reset exits through one recover cycle, so the core stays
    // held while reset is up and restores from the reset arch map
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_RECOVER;
        end else if (state == ST_RUN) begin
            if (flush) begin
                state <= ST_RECOVER;
            end
        end else begin
            state <= ST_RUN;  // exactly one cycle, a flush here is dropped
        end
    end

    // hold covers the flush cycle itself, before state moves
    assign hold    = flush || (state == ST_RECOVER);
    assign restore = (state == ST_RECOVER);

endmodule

`default_nettype wire

// File: rename/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                dispatch_fire,  // rename this cycle
    input  wire rename_pkg::ar_idx_t dest_ar,
    input  wire rename_pkg::pr_idx_t free_pr,        // new mapping of dest_ar
    input  wire rename_pkg::ar_idx_t src1_ar,
    input  wire rename_pkg::ar_idx_t src2_ar,
    input  wire logic                cdb_valid,      // completion broadcast
    input  wire rename_pkg::pr_idx_t cdb_pr,
    input  wire logic                restore,
    input  wire rename_pkg::pr_idx_t [rename_pkg::NUM_AR-1:0] arch_map,
    output rename_pkg::pr_idx_t      old_pr,
    output rename_pkg::pr_idx_t      src1_pr,
    output rename_pkg::pr_idx_t      src2_pr,
    output logic                     src1_ready,
    output logic                     src2_ready
);
    import rename_pkg::*;

    pr_idx_t [NUM_AR-1:0] map_q;    // speculative ar -> pr
    logic    [NUM_PR-1:0] ready_q;  // one bit per pr, value produced

    ////////////////////////////////////////
    // table update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_AR; i++) begin
                map_q[i] <= pr_idx_t'(i);  // identity
            end
            ready_q <= '1;
        end else if (restore) begin
            map_q   <= arch_map;  // drop all speculative renames
            ready_q <= '1;        // committed values are all written
        end else begin
            if (cdb_valid) begin
                ready_q[cdb_pr] <= 1'b1;
            end
            // cdb never names the free pr, both writes can land
            if (dispatch_fire) begin
                map_q[dest_ar]   <= free_pr;
                ready_q[free_pr] <= 1'b0;  // pending until its completion
            end
        end
    end

    ////////////////////////////////////////
    // lookup, before this instr's own rename
    ////////////////////////////////////////

    assign old_pr  = map_q[dest_ar];  // goes to the rob for retire
    assign src1_pr = map_q[src1_ar];
    assign src2_pr = map_q[src2_ar];

    // bypass a completion in the same cycle
    assign src1_ready = ready_q[src1_pr] || (cdb_valid && (cdb_pr == src1_pr));
    assign src2_ready = ready_q[src2_pr] || (cdb_valid && (cdb_pr == src2_pr));

endmodule

`default_nettype wire

// File: rename/arch_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module arch_map_table (
    input  wire logic                 clock,
    input  wire logic                 reset,
    retire_if.sink                    retire,    // in-order commits from rob
    output rename_pkg::pr_idx_t [rename_pkg::NUM_AR-1:0] arch_map
);
    import rename_pkg::*;

    ////////////////////////////////////////
    // committed map
    ////////////////////////////////////////

    // only retired renames land here, so on a flush this is
    // exactly the state the speculative map must fall back to
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_AR; i++) begin
                arch_map[i] <= pr_idx_t'(i);  // ar i -> pr i
            end
        end else if (retire.valid) begin
            arch_map[retire.ar] <= retire.pr_new;  // one commit per cycle
        end
    end

    // pr_old of the same commit is freed by the free list,
    // it is no longer named by any committed entry

endmodule

`default_nettype wire

// File: rename/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           dispatch_fire,   // pop head
    retire_if.sink              retire,          // push pr_old at tail
    input  wire logic           restore,
    output rename_pkg::pr_idx_t free_pr,         // next pr handed out
    output logic                free_available
);
    import rename_pkg::*;

    pr_idx_t                       ring_q [FREE_DEPTH];  // free pr storage
    logic [$clog2(FREE_DEPTH)-1:0] head;
    logic [$clog2(FREE_DEPTH)-1:0] tail;
    logic                          empty;

    ////////////////////////////////////////
    // pointers
    ////////////////////////////////////////

    // restore only moves head back to tail, the prs handed out since the
    // last commit are still sitting in the slots between them
    ring_counter #(
        .DEPTH (FREE_DEPTH)
    ) ptrs (
        .clock (clock),
        .reset (reset),
        .push  (retire.valid),
        .pop   (dispatch_fire),
        .clear (1'b0),
        .fill  (reset || restore),  // reset and recover both leave it full
        .head  (head),
        .tail  (tail),
        .empty (empty),
        .full  ()
    );

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                ring_q[i] <= pr_idx_t'(NUM_AR + i);  // prs 32..63, head first
            end
        end else if (retire.valid) begin
            ring_q[tail] <= retire.pr_old;
        end
    end

    assign free_pr        = ring_q[head];
    assign free_available = !empty;

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 dispatch_valid,
    input  wire rename_pkg::ar_idx_t  dest_ar,
    input  wire rename_pkg::pr_idx_t  dest_pr,         // new mapping
    input  wire rename_pkg::pr_idx_t  old_pr,          // mapping it replaces
    input  wire logic                 free_available,
    input  wire logic                 complete_valid,
    input  wire rename_pkg::rob_idx_t complete_rob_index,
    input  wire logic                 hold,            // flush / recover
    input  wire logic                 restore,
    output logic                      dispatch_ready,
    output logic                      dispatch_fire,
    output rename_pkg::rob_idx_t      rob_index,       // slot of this dispatch
    output logic                      cdb_valid,
    output rename_pkg::pr_idx_t       cdb_pr,
    retire_if.source                  retire
);
    import rename_pkg::*;

    // entry payload, written once at dispatch
    ar_idx_t              ar_q     [ROB_DEPTH];
    pr_idx_t              pr_new_q [ROB_DEPTH];
    pr_idx_t              pr_old_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;  // completed, may retire

    rob_idx_t head;
    rob_idx_t tail;
    logic     empty;
    logic     full;

    ring_counter #(
        .DEPTH (ROB_DEPTH)
    ) ptrs (
        .clock (clock),
        .reset (reset),
        .push  (dispatch_fire),
        .pop   (retire.valid),
        .clear (restore),  // flush drops every entry, done or not
        .fill  (1'b0),
        .head  (head),
        .tail  (tail),
        .empty (empty),
        .full  (full)
    );

    ////////////////////////////////////////
    // dispatch
    ////////////////////////////////////////

    assign dispatch_ready = !hold && !full && free_available;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign rob_index      = tail;

    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            ar_q[tail]     <= dest_ar;
            pr_new_q[tail] <= dest_pr;
            pr_old_q[tail] <= old_pr;
        end
    end

    ////////////////////////////////////////
    // completion
    ////////////////////////////////////////

    assign cdb_valid = complete_valid && !hold;
    assign cdb_pr    = pr_new_q[complete_rob_index];  // wakes the map's ready bit

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= '0;
        end else begin
            if (dispatch_fire) begin
                done_q[tail] <= 1'b0;  // fresh entry
            end
            if (cdb_valid) begin
                done_q[complete_rob_index] <= 1'b1;  // any order
            end
        end
    end

    ////////////////////////////////////////
    // retirement, head only
    ////////////////////////////////////////

    assign retire.valid  = !hold && !empty && done_q[head];
    assign retire.ar     = ar_q[head];
    assign retire.pr_new = pr_new_q[head];
    assign retire.pr_old = pr_old_q[head];

endmodule

`default_nettype wire

// File: hdl/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                dispatch_valid,
    input  wire rename_pkg::ar_idx_t dest_ar,
    input  wire rename_pkg::ar_idx_t src1_ar,
    input  wire rename_pkg::ar_idx_t src2_ar,
    input  wire logic                complete_valid,
    input  wire rename_pkg::rob_idx_t complete_rob_index,
    input  wire logic                flush,
    output logic                     dispatch_ready,
    output rename_pkg::pr_idx_t      dest_pr,
    output rename_pkg::pr_idx_t      old_pr,
    output rename_pkg::pr_idx_t      src1_pr,
    output rename_pkg::pr_idx_t      src2_pr,
    output logic                     src1_ready,
    output logic                     src2_ready,
    output rename_pkg::rob_idx_t     rob_index,
    output logic                     retire_valid,
    output rename_pkg::ar_idx_t      retire_ar,
    output rename_pkg::pr_idx_t      retire_pr
);
    import rename_pkg::*;

    logic                 hold;            // blocks dispatch / complete / retire
    logic                 restore;         // recover cycle
    logic                 dispatch_fire;   // rename accepted this cycle
    logic                 free_available;  // free list not empty
    logic                 cdb_valid;
    pr_idx_t              cdb_pr;
    pr_idx_t [NUM_AR-1:0] arch_map;        // committed table for recovery

    retire_if retire_bus ();

    ////////////////////////////////////////
    // flush sequencing
    ////////////////////////////////////////

    recovery_fsm recovery_fsm_0 (
        .clock   (clock),
        .reset   (reset),
        .flush   (flush),
        .hold    (hold),     // -> rob
        .restore (restore)   // -> rob, map, free list
    );

    ////////////////////////////////////////
    // rename tables
    ////////////////////////////////////////

    map_table map_table_0 (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),  // <- rob
        .dest_ar       (dest_ar),
        .free_pr       (dest_pr),        // <- free list head
        .src1_ar       (src1_ar),
        .src2_ar       (src2_ar),
        .cdb_valid     (cdb_valid),      // <- rob completion
        .cdb_pr        (cdb_pr),
        .restore       (restore),
        .arch_map      (arch_map),       // <- arch map
        .old_pr        (old_pr),
        .src1_pr       (src1_pr),
        .src2_pr       (src2_pr),
        .src1_ready    (src1_ready),
        .src2_ready    (src2_ready)
    );

    arch_map_table arch_map_table_0 (
        .clock    (clock),
        .reset    (reset),
        .retire   (retire_bus.sink),
        .arch_map (arch_map)             // -> map table
    );

    free_list free_list_0 (
        .clock          (clock),
        .reset          (reset),
        .dispatch_fire  (dispatch_fire),
        .retire         (retire_bus.sink),
        .restore        (restore),
        .free_pr        (dest_pr),        // new pr for this dispatch
        .free_available (free_available)  // -> rob dispatch gating
    );

    ////////////////////////////////////////
    // reorder buffer
    ////////////////////////////////////////

    reorder_buffer reorder_buffer_0 (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dest_ar            (dest_ar),
        .dest_pr            (dest_pr),
        .old_pr             (old_pr),
        .free_available     (free_available),
        .complete_valid     (complete_valid),
        .complete_rob_index (complete_rob_index),
        .hold               (hold),
        .restore            (restore),
        .dispatch_ready     (dispatch_ready),
        .dispatch_fire      (dispatch_fire),
        .rob_index          (rob_index),
        .cdb_valid          (cdb_valid),   // -> map table ready bits
        .cdb_pr             (cdb_pr),
        .retire             (retire_bus.source)
    );

    // retire bundle out to the pins
    assign retire_valid = retire_bus.valid;
    assign retire_ar    = retire_bus.ar;
    assign retire_pr    = retire_bus.pr_new;

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, 100 ns period
module tb_clock (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;  // half period
        end
    end

endmodule

`default_nettype wire

// File: verif/rename_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_tb;
    import rename_pkg::*;

    localparam int NUM_CYCLES  = 2000;                // random stimulus cycles
    localparam int CYCLE_LIMIT = 2 * NUM_CYCLES + 1000;  // watchdog limit in cycles

    wire clock;

    // dut inputs
    logic     reset;
    logic     dispatch_valid;
    ar_idx_t  dest_ar;
    ar_idx_t  src1_ar;
    ar_idx_t  src2_ar;
    logic     complete_valid;
    rob_idx_t complete_rob_index;
    logic     flush;

    // dut outputs
    logic     dispatch_ready;
    pr_idx_t  dest_pr;
    pr_idx_t  old_pr;
    pr_idx_t  src1_pr;
    pr_idx_t  src2_pr;
    logic     src1_ready;
    logic     src2_ready;
    rob_idx_t rob_index;
    logic     retire_valid;
    ar_idx_t  retire_ar;
    pr_idx_t  retire_pr;

    ////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////

    int m_spec_map [NUM_AR];     // speculative ar -> pr
    bit m_ready    [NUM_PR];
    int m_arch_map [NUM_AR];     // committed ar -> pr
    int m_fl_ring  [FREE_DEPTH];
    int m_fl_head;
    int m_fl_tail;
    int m_fl_count;
    int m_rob_ar   [ROB_DEPTH];
    int m_rob_new  [ROB_DEPTH];
    int m_rob_old  [ROB_DEPTH];
    bit m_rob_done [ROB_DEPTH];
    int m_rob_head;
    int m_rob_tail;
    int m_rob_count;
    bit m_recovering;            // reset exits through a recover cycle too

    int seed = 79862;
    int cycle_count = 0;
    int n_fire = 0;
    int n_retire = 0;
    int n_flush = 0;
    int n_full = 0;
    int n_bypass = 0;

    tb_clock clock_gen (
        .clock (clock)
    );

    rename_core dut0 (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dest_ar            (dest_ar),
        .src1_ar            (src1_ar),
        .src2_ar            (src2_ar),
        .complete_valid     (complete_valid),
        .complete_rob_index (complete_rob_index),
        .flush              (flush),
        .dispatch_ready     (dispatch_ready),
        .dest_pr            (dest_pr),
        .old_pr             (old_pr),
        .src1_pr            (src1_pr),
        .src2_pr            (src2_pr),
        .src1_ready         (src1_ready),
        .src2_ready         (src2_ready),
        .rob_index          (rob_index),
        .retire_valid       (retire_valid),
        .retire_ar          (retire_ar),
        .retire_pr          (retire_pr)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < NUM_AR; i++) begin
            m_spec_map[i] = i;  // identity
            m_arch_map[i] = i;
        end
        for (int i = 0; i < NUM_PR; i++) begin
            m_ready[i] = 1'b1;
        end
        for (int i = 0; i < FREE_DEPTH; i++) begin
            m_fl_ring[i] = NUM_AR + i;  // prs 32..63
        end
        m_fl_head    = 0;
        m_fl_tail    = 0;
        m_fl_count   = FREE_DEPTH;
        m_rob_head   = 0;
        m_rob_tail   = 0;
        m_rob_count  = 0;
        m_recovering = 1'b1;
    endtask

    // new inputs for the coming cycle chosen from model state
    task automatic drive_random(int cycle);
        int  outstanding [$];
        int  idx;
        int  disp_pct;
        int  comp_pct;
        bit  busy_phase;
        busy_phase = ((cycle / 200) % 2) == 0;  // alternate fill and drain
        disp_pct   = busy_phase ? 85 : 50;
        comp_pct   = busy_phase ? 25 : 90;
        for (int i = 0; i < m_rob_count; i++) begin
            idx = (m_rob_head + i) % ROB_DEPTH;
            if (!m_rob_done[idx]) begin
                outstanding.push_back(idx);
            end
        end
        dispatch_valid <= ({$random(seed)} % 100) < disp_pct;
        dest_ar        <= ar_idx_t'({$random(seed)} % 12);  // few dests so each renames often
        src1_ar        <= ar_idx_t'({$random(seed)} % 16);  // 12..15 never renamed
        src2_ar        <= ar_idx_t'({$random(seed)} % 16);
        if (outstanding.size() > 0 && ({$random(seed)} % 100) < comp_pct) begin
            complete_valid     <= 1'b1;
            complete_rob_index <= rob_idx_t'(outstanding[{$random(seed)} % outstanding.size()]);
        end else begin
            complete_valid     <= 1'b0;
            complete_rob_index <= rob_idx_t'($random(seed));  // don't care
        end
        flush <= ({$random(seed)} % 128) == 0;  // rare mispredict
    endtask

    // compare outputs mid cycle and then step the model past the edge
    task automatic check_and_step();
        bit hold;
        bit restore;
        bit exp_ready;
        bit fire;
        bit retire;
        bit cdb;
        bit s1_rdy;
        bit s2_rdy;
        int cdb_pr_m;
        int s1;
        int s2;
        int new_pr;
        int prev_pr;
        int r_ar;
        int r_new;
        int r_old;
        restore   = m_recovering;
        hold      = flush || m_recovering;
        exp_ready = !hold && (m_rob_count != ROB_DEPTH) && (m_fl_count != 0);
        fire      = dispatch_valid && exp_ready;
        retire    = !hold && (m_rob_count != 0) && m_rob_done[m_rob_head];
        cdb       = complete_valid && !hold;
        cdb_pr_m  = m_rob_new[complete_rob_index];
        s1        = m_spec_map[src1_ar];
        s2        = m_spec_map[src2_ar];
        s1_rdy    = m_ready[s1] || (cdb && cdb_pr_m == s1);  // same cycle bypass
        s2_rdy    = m_ready[s2] || (cdb && cdb_pr_m == s2);
        new_pr    = m_fl_ring[m_fl_head];
        prev_pr   = m_spec_map[dest_ar];
        r_ar      = m_rob_ar[m_rob_head];
        r_new     = m_rob_new[m_rob_head];
        r_old     = m_rob_old[m_rob_head];

        compare_value("dispatch_ready", exp_ready, dispatch_ready);
        compare_value("retire_valid", retire, retire_valid);
        compare_value("src1_pr", s1, src1_pr);
        compare_value("src2_pr", s2, src2_pr);
        compare_value("src1_ready", s1_rdy, src1_ready);
        compare_value("src2_ready", s2_rdy, src2_ready);
        if (fire) begin
            compare_value("dest_pr", new_pr, dest_pr);
            compare_value("old_pr", prev_pr, old_pr);
            compare_value("rob_index", m_rob_tail, rob_index);
        end
        if (retire) begin
            compare_value("retire_ar", r_ar, retire_ar);
            compare_value("retire_pr", r_new, retire_pr);
        end

        if (m_rob_count == ROB_DEPTH) begin
            n_full++;
        end
        if (cdb && ((cdb_pr_m == s1 && !m_ready[s1]) || (cdb_pr_m == s2 && !m_ready[s2]))) begin
            n_bypass++;
        end

        if (restore) begin
            // recover cycle restores the committed state
            for (int i = 0; i < NUM_AR; i++) begin
                m_spec_map[i] = m_arch_map[i];
            end
            for (int i = 0; i < NUM_PR; i++) begin
                m_ready[i] = 1'b1;
            end
            m_fl_head   = m_fl_tail;
            m_fl_count  = FREE_DEPTH;
            m_rob_head  = 0;
            m_rob_tail  = 0;
            m_rob_count = 0;
        end else if (!flush) begin
            if (cdb) begin
                m_ready[cdb_pr_m]              = 1'b1;
                m_rob_done[complete_rob_index] = 1'b1;
            end
            if (retire) begin
                m_arch_map[r_ar]     = r_new;
                m_fl_ring[m_fl_tail] = r_old;  // old mapping back on the ring
                m_fl_tail            = (m_fl_tail + 1) % FREE_DEPTH;
                m_fl_count++;
                m_rob_head = (m_rob_head + 1) % ROB_DEPTH;
                m_rob_count--;
                n_retire++;
            end
            if (fire) begin
                m_spec_map[dest_ar]    = new_pr;
                m_ready[new_pr]        = 1'b0;
                m_rob_ar[m_rob_tail]   = dest_ar;
                m_rob_new[m_rob_tail]  = new_pr;
                m_rob_old[m_rob_tail]  = prev_pr;
                m_rob_done[m_rob_tail] = 1'b0;
                m_rob_tail = (m_rob_tail + 1) % ROB_DEPTH;
                m_rob_count++;
                m_fl_head = (m_fl_head + 1) % FREE_DEPTH;
                m_fl_count--;
                n_fire++;
            end
        end
        if (!restore && flush) begin
            n_flush++;  // a flush in the recover cycle is dropped
        end
        m_recovering = !restore && flush;
    endtask

    ////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        reset              = 1'b1;
        dispatch_valid     = 1'b0;
        dest_ar            = '0;
        src1_ar            = '0;
        src2_ar            = '0;
        complete_valid     = 1'b0;
        complete_rob_index = '0;
        flush              = 1'b0;
        reset_model();

        @(posedge clock);  // first reset edge
        @(negedge clock);
        compare_value("reset_dispatch_ready", 0, dispatch_ready);
        compare_value("reset_retire_valid", 0, retire_valid);
        @(posedge clock);  // second reset edge
        reset <= 1'b0;

        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_random(c);
            @(negedge clock);
            check_and_step();
            @(posedge clock);
        end

        // the run must have hit back-pressure, flushes, retires and bypasses
        compare_value("rob_full_seen", 1, n_full > 0);
        compare_value("flush_seen", 1, n_flush > 0);
        compare_value("retire_seen", 1, n_retire > 0);
        compare_value("bypass_seen", 1, n_bypass > 0);
        $display("dispatched %0d retired %0d flushes %0d full cycles %0d bypasses %0d",
                 n_fire, n_retire, n_flush, n_full, n_bypass);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/rename_pkg.sv
common/retire_if.sv
hdl/ring_counter.sv
hdl/recovery_fsm.sv
rename/map_table.sv
rename/arch_map_table.sv
rename/free_list.sv
rob/reorder_buffer.sv
hdl/rename_core.sv
verif/tb_clock.sv
verif/rename_tb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - files:
      - common/rename_pkg.sv
      - common/retire_if.sv
      - hdl/ring_counter.sv
      - hdl/recovery_fsm.sv
      - rename/map_table.sv
      - rename/arch_map_table.sv
      - rename/free_list.sv
      - rob/reorder_buffer.sv
      - hdl/rename_core.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/rename_tb.sv
